// File: hw/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_RESP_W 2

// SRAM size in words
`define SRAM_DEPTH 256

// Peripheral register map
`define UART_TX_ADDR        32'ha00003f8
`define CLINT_MTIMECMP_ADDR 32'ha0000048
`define CLINT_MTIME_ADDR    32'ha000bff8

`endif

// File: hw/soc_bus_pkg.sv
`default_nettype none

`include "soc_params.svh"

package soc_bus_pkg;

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [`AXI_RESP_W-1:0] axi_resp_t;

    // Crossbar target
    typedef enum logic [1:0] {
        sel_sram,
        sel_uart,
        sel_clint
    } slave_sel_t;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

endpackage

`default_nettype wire

// File: hw/axi_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if
    import soc_bus_pkg::*;
();

    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;

    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;

    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;

    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

`default_nettype wire

// File: hw/axi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter
    import soc_bus_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    axi_lite_if.slave  m0,
    axi_lite_if.slave  m1,
    axi_lite_if.master down
);

    arb_state_t state;
    logic       owner;
    logic       prio;
    logic       addr_sent;
    logic       req0;
    logic       req1;
    logic       pick;
    logic       pass;
    logic       fwd0;
    logic       fwd1;
    logic       own0;
    logic       own1;
    logic       addr_hs;
    logic       done;

    assign req0 = m0.arvalid || (m0.awvalid && m0.wvalid);
    assign req1 = m1.arvalid || (m1.awvalid && m1.wvalid);
    // prio high favours m1
    assign pick = prio ? req1 : !req0;

    assign pass = (state == arb_busy) && !addr_sent;
    assign fwd0 = pass && !owner;
    assign fwd1 = pass && owner;
    assign own0 = (state == arb_busy) && !owner;
    assign own1 = (state == arb_busy) && owner;

    assign addr_hs = (down.arvalid && down.arready) || (down.awvalid && down.awready);
    assign done = (down.rvalid && down.rready) || (down.bvalid && down.bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= arb_idle;
            owner     <= 1'b0;
            prio      <= 1'b1;
            addr_sent <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (req0 || req1) begin
                        state     <= arb_busy;
                        owner     <= pick;
                        addr_sent <= 1'b0;
                    end
                end
                arb_busy: begin
                    if (addr_hs)
                        addr_sent <= 1'b1;
                    if (done) begin
                        state <= arb_idle;
                        prio  <= ~owner;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // Requests of the owner only
    assign down.araddr  = owner ? m1.araddr : m0.araddr;
    assign down.awaddr  = owner ? m1.awaddr : m0.awaddr;
    assign down.wdata   = owner ? m1.wdata : m0.wdata;
    assign down.wstrb   = owner ? m1.wstrb : m0.wstrb;
    assign down.arvalid = owner ? fwd1 && m1.arvalid : fwd0 && m0.arvalid;
    assign down.awvalid = owner ? fwd1 && m1.awvalid : fwd0 && m0.awvalid;
    assign down.wvalid  = owner ? fwd1 && m1.wvalid : fwd0 && m0.wvalid;
    assign down.rready  = owner ? own1 && m1.rready : own0 && m0.rready;
    assign down.bready  = owner ? own1 && m1.bready : own0 && m0.bready;

    assign m0.arready = fwd0 && down.arready;
    assign m0.awready = fwd0 && down.awready;
    assign m0.wready  = fwd0 && down.wready;
    assign m0.rdata   = down.rdata;
    assign m0.rresp   = down.rresp;
    assign m0.rvalid  = own0 && down.rvalid;
    assign m0.bresp   = down.bresp;
    assign m0.bvalid  = own0 && down.bvalid;

    assign m1.arready = fwd1 && down.arready;
    assign m1.awready = fwd1 && down.awready;
    assign m1.wready  = fwd1 && down.wready;
    assign m1.rdata   = down.rdata;
    assign m1.rresp   = down.rresp;
    assign m1.rvalid  = own1 && down.rvalid;
    assign m1.bresp   = down.bresp;
    assign m1.bvalid  = own1 && down.bvalid;

    // No slave may still be answering when a new grant can be made
    a_no_grant_open_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (state == arb_idle) |-> !(down.rvalid || down.bvalid));

endmodule

`default_nettype wire

// File: hw/axi_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module axi_xbar
    import soc_bus_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    axi_lite_if.slave  up,
    axi_lite_if.master s0,
    axi_lite_if.master s1,
    axi_lite_if.master s2
);

    slave_sel_t sel_dec;
    slave_sel_t sel_q;
    slave_sel_t route;
    logic       resp_open;
    logic       req_ok;
    logic       wr_ok;
    logic       hit0;
    logic       hit1;
    logic       hit2;
    logic       addr_hs;
    logic       resp_hs;

    function automatic slave_sel_t decode(input axi_addr_t addr);
        if (addr == `UART_TX_ADDR)
            return sel_uart;
        if (addr == `CLINT_MTIMECMP_ADDR || addr == `CLINT_MTIME_ADDR)
            return sel_clint;
        return sel_sram;
    endfunction

    // Read address wins the decode when both are offered
    assign sel_dec = decode(up.arvalid ? up.araddr : up.awaddr);
    assign route   = resp_open ? sel_q : sel_dec;
    assign req_ok  = !resp_open;
    assign wr_ok   = req_ok && !up.arvalid;
    assign hit0    = (route == sel_sram);
    assign hit1    = (route == sel_uart);
    assign hit2    = (route == sel_clint);

    assign addr_hs = (up.arvalid && up.arready) || (up.awvalid && up.awready);
    assign resp_hs = (up.rvalid && up.rready) || (up.bvalid && up.bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_open <= 1'b0;
            sel_q     <= sel_sram;
        end else if (addr_hs) begin
            resp_open <= 1'b1;
            sel_q     <= sel_dec;
        end else if (resp_hs) begin
            resp_open <= 1'b0;
        end
    end

    assign s0.araddr  = up.araddr;
    assign s0.arvalid = up.arvalid && req_ok && hit0;
    assign s0.rready  = up.rready && hit0;
    assign s0.awaddr  = up.awaddr;
    assign s0.awvalid = up.awvalid && wr_ok && hit0;
    assign s0.wdata   = up.wdata;
    assign s0.wstrb   = up.wstrb;
    assign s0.wvalid  = up.wvalid && wr_ok && hit0;
    assign s0.bready  = up.bready && hit0;

    assign s1.araddr  = up.araddr;
    assign s1.arvalid = up.arvalid && req_ok && hit1;
    assign s1.rready  = up.rready && hit1;
    assign s1.awaddr  = up.awaddr;
    assign s1.awvalid = up.awvalid && wr_ok && hit1;
    assign s1.wdata   = up.wdata;
    assign s1.wstrb   = up.wstrb;
    assign s1.wvalid  = up.wvalid && wr_ok && hit1;
    assign s1.bready  = up.bready && hit1;

    assign s2.araddr  = up.araddr;
    assign s2.arvalid = up.arvalid && req_ok && hit2;
    assign s2.rready  = up.rready && hit2;
    assign s2.awaddr  = up.awaddr;
    assign s2.awvalid = up.awvalid && wr_ok && hit2;
    assign s2.wdata   = up.wdata;
    assign s2.wstrb   = up.wstrb;
    assign s2.wvalid  = up.wvalid && wr_ok && hit2;
    assign s2.bready  = up.bready && hit2;

    assign up.arready = req_ok && (hit1 ? s1.arready : hit2 ? s2.arready : s0.arready);
    assign up.awready = wr_ok && (hit1 ? s1.awready : hit2 ? s2.awready : s0.awready);
    assign up.wready  = wr_ok && (hit1 ? s1.wready : hit2 ? s2.wready : s0.wready);
    assign up.rdata   = hit1 ? s1.rdata : hit2 ? s2.rdata : s0.rdata;
    assign up.rresp   = hit1 ? s1.rresp : hit2 ? s2.rresp : s0.rresp;
    assign up.rvalid  = hit1 ? s1.rvalid : hit2 ? s2.rvalid : s0.rvalid;
    assign up.bresp   = hit1 ? s1.bresp : hit2 ? s2.bresp : s0.bresp;
    assign up.bvalid  = hit1 ? s1.bvalid : hit2 ? s2.bvalid : s0.bvalid;

    // A slave answering must match the selection latched at its address transfer
    a_sel_sram: assert property (@(posedge clk) disable iff (!rst_n)
        (s0.rvalid || s0.bvalid) |-> (resp_open && sel_q == sel_sram));
    a_sel_uart: assert property (@(posedge clk) disable iff (!rst_n)
        (s1.rvalid || s1.bvalid) |-> (resp_open && sel_q == sel_uart));
    a_sel_clint: assert property (@(posedge clk) disable iff (!rst_n)
        (s2.rvalid || s2.bvalid) |-> (resp_open && sel_q == sel_clint));

endmodule

`default_nettype wire

// File: hw/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module axi_sram
    import soc_bus_pkg::*;
#(
    parameter int SRAM_DEPTH = `SRAM_DEPTH
) (
    input logic       clk,
    input logic       rst_n,
    axi_lite_if.slave bus
);

    localparam int IDX_W = $clog2(SRAM_DEPTH);

    axi_data_t        mem [SRAM_DEPTH];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             pending;
    logic             wr_go;

    // Word index wraps at the depth
    assign rd_idx = bus.araddr[IDX_W+1:2];
    assign wr_idx = bus.awaddr[IDX_W+1:2];

    assign pending     = bus.rvalid || bus.bvalid;
    assign bus.arready = bus.arvalid && !pending;
    assign wr_go       = bus.awvalid && bus.wvalid && !bus.arvalid && !pending;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.rresp   = '0;
    assign bus.bresp   = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
        end else begin
            if (bus.arready)
                bus.rvalid <= 1'b1;
            else if (bus.rready)
                bus.rvalid <= 1'b0;
            if (wr_go)
                bus.bvalid <= 1'b1;
            else if (bus.bready)
                bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arready)
            bus.rdata <= mem[rd_idx];
        if (wr_go) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (bus.wstrb[i])
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/axi_uart.sv
`timescale 1ns/1ps
`default_nettype none

module axi_uart (
    input logic        clk,
    input logic        rst_n,
    axi_lite_if.slave  bus,
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    logic pending;
    logic wr_go;

    assign pending     = bus.rvalid || bus.bvalid;
    assign bus.arready = bus.arvalid && !pending;
    assign wr_go       = bus.awvalid && bus.wvalid && !bus.arvalid && !pending;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    // Transmit register reads back as zero
    assign bus.rdata   = '0;
    assign bus.rresp   = '0;
    assign bus.bresp   = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
            tx_valid   <= 1'b0;
        end else begin
            if (bus.arready)
                bus.rvalid <= 1'b1;
            else if (bus.rready)
                bus.rvalid <= 1'b0;
            if (wr_go)
                bus.bvalid <= 1'b1;
            else if (bus.bready)
                bus.bvalid <= 1'b0;
            // One-cycle strobe per accepted byte
            tx_valid <= wr_go && bus.wstrb[0];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go && bus.wstrb[0])
            tx_data <= bus.wdata[7:0];
    end

endmodule

`default_nettype wire

// File: hw/axi_clint.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module axi_clint
    import soc_bus_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    axi_lite_if.slave bus,
    output logic      timer_irq
);

    axi_data_t mtime;
    axi_data_t mtimecmp;
    logic      pending;
    logic      wr_go;

    assign pending     = bus.rvalid || bus.bvalid;
    assign bus.arready = bus.arvalid && !pending;
    assign wr_go       = bus.awvalid && bus.wvalid && !bus.arvalid && !pending;
    assign bus.awready = wr_go;
    assign bus.wready  = wr_go;
    assign bus.rresp   = '0;
    assign bus.bresp   = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
            mtime      <= '0;
            mtimecmp   <= '1;
            timer_irq  <= 1'b0;
        end else begin
            if (bus.arready)
                bus.rvalid <= 1'b1;
            else if (bus.rready)
                bus.rvalid <= 1'b0;
            if (wr_go)
                bus.bvalid <= 1'b1;
            else if (bus.bready)
                bus.bvalid <= 1'b0;
            mtime <= mtime + 1'b1;
            // Writes to mtime are ignored
            if (wr_go && bus.awaddr == `CLINT_MTIMECMP_ADDR) begin
                for (int i = 0; i < `AXI_STRB_W; i++) begin
                    if (bus.wstrb[i])
                        mtimecmp[8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arready)
            bus.rdata <= (bus.araddr == `CLINT_MTIME_ADDR) ? mtime : mtimecmp;
    end

endmodule

`default_nettype wire

// File: hw/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top
    import soc_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Instruction fetch master
    input  axi_addr_t m0_araddr,
    input  logic      m0_arvalid,
    output logic      m0_arready,
    output axi_data_t m0_rdata,
    output axi_resp_t m0_rresp,
    output logic      m0_rvalid,
    input  logic      m0_rready,
    input  axi_addr_t m0_awaddr,
    input  logic      m0_awvalid,
    output logic      m0_awready,
    input  axi_data_t m0_wdata,
    input  axi_strb_t m0_wstrb,
    input  logic      m0_wvalid,
    output logic      m0_wready,
    output axi_resp_t m0_bresp,
    output logic      m0_bvalid,
    input  logic      m0_bready,

    // Load/store master
    input  axi_addr_t m1_araddr,
    input  logic      m1_arvalid,
    output logic      m1_arready,
    output axi_data_t m1_rdata,
    output axi_resp_t m1_rresp,
    output logic      m1_rvalid,
    input  logic      m1_rready,
    input  axi_addr_t m1_awaddr,
    input  logic      m1_awvalid,
    output logic      m1_awready,
    input  axi_data_t m1_wdata,
    input  axi_strb_t m1_wstrb,
    input  logic      m1_wvalid,
    output logic      m1_wready,
    output axi_resp_t m1_bresp,
    output logic      m1_bvalid,
    input  logic      m1_bready,

    output logic [7:0] uart_tx_data,
    output logic       uart_tx_valid,
    output logic       timer_irq
);

    axi_lite_if m0_bus ();
    axi_lite_if m1_bus ();
    axi_lite_if arb_bus ();
    axi_lite_if sram_bus ();
    axi_lite_if uart_bus ();
    axi_lite_if clint_bus ();

    assign m0_bus.araddr  = m0_araddr;
    assign m0_bus.arvalid = m0_arvalid;
    assign m0_bus.rready  = m0_rready;
    assign m0_bus.awaddr  = m0_awaddr;
    assign m0_bus.awvalid = m0_awvalid;
    assign m0_bus.wdata   = m0_wdata;
    assign m0_bus.wstrb   = m0_wstrb;
    assign m0_bus.wvalid  = m0_wvalid;
    assign m0_bus.bready  = m0_bready;
    assign m0_arready     = m0_bus.arready;
    assign m0_rdata       = m0_bus.rdata;
    assign m0_rresp       = m0_bus.rresp;
    assign m0_rvalid      = m0_bus.rvalid;
    assign m0_awready     = m0_bus.awready;
    assign m0_wready      = m0_bus.wready;
    assign m0_bresp       = m0_bus.bresp;
    assign m0_bvalid      = m0_bus.bvalid;

    assign m1_bus.araddr  = m1_araddr;
    assign m1_bus.arvalid = m1_arvalid;
    assign m1_bus.rready  = m1_rready;
    assign m1_bus.awaddr  = m1_awaddr;
    assign m1_bus.awvalid = m1_awvalid;
    assign m1_bus.wdata   = m1_wdata;
    assign m1_bus.wstrb   = m1_wstrb;
    assign m1_bus.wvalid  = m1_wvalid;
    assign m1_bus.bready  = m1_bready;
    assign m1_arready     = m1_bus.arready;
    assign m1_rdata       = m1_bus.rdata;
    assign m1_rresp       = m1_bus.rresp;
    assign m1_rvalid      = m1_bus.rvalid;
    assign m1_awready     = m1_bus.awready;
    assign m1_wready      = m1_bus.wready;
    assign m1_bresp       = m1_bus.bresp;
    assign m1_bvalid      = m1_bus.bvalid;

    axi_arbiter i_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (m0_bus),
        .m1    (m1_bus),
        .down  (arb_bus)
    );

    axi_xbar i_xbar (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (arb_bus),
        .s0    (sram_bus),
        .s1    (uart_bus),
        .s2    (clint_bus)
    );

    axi_sram i_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_bus)
    );

    axi_uart i_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (uart_bus),
        .tx_data  (uart_tx_data),
        .tx_valid (uart_tx_valid)
    );

    axi_clint i_clint (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (clint_bus),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// File: sim/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module tb_soc_bus
    import soc_bus_pkg::*;
();

    localparam int PERIOD = 20;
    localparam int QTR    = PERIOD / 4;

    typedef enum logic [2:0] {
        op_write,
        op_read,
        op_uart,
        op_mtime,
        op_irq,
        op_dual,
        op_stall
    } tb_op_t;

    typedef struct packed {
        tb_op_t     op;
        logic       master;
        axi_addr_t  addr;
        axi_data_t  data;
        axi_strb_t  strb;
        logic [7:0] hold;
        axi_data_t  exp_a;
        axi_data_t  exp_b;
    } entry_t;

    logic clk;
    logic rst_n;

    // Index 0 is m0 and index 1 is m1
    logic [1:0][`AXI_ADDR_W-1:0] araddr;
    logic [1:0]                  arvalid;
    logic [1:0]                  rready;
    logic [1:0][`AXI_ADDR_W-1:0] awaddr;
    logic [1:0]                  awvalid;
    logic [1:0][`AXI_DATA_W-1:0] wdata;
    logic [1:0][`AXI_STRB_W-1:0] wstrb;
    logic [1:0]                  wvalid;
    logic [1:0]                  bready;
    wire  [1:0]                  arready;
    wire  [1:0][`AXI_DATA_W-1:0] rdata;
    wire  [1:0][`AXI_RESP_W-1:0] rresp;
    wire  [1:0]                  rvalid;
    wire  [1:0]                  awready;
    wire  [1:0]                  wready;
    wire  [1:0][`AXI_RESP_W-1:0] bresp;
    wire  [1:0]                  bvalid;
    wire  [7:0]                  uart_tx_data;
    wire                         uart_tx_valid;
    wire                         timer_irq;

    entry_t      table_q [$];
    string       names_q [$];
    axi_data_t   sram_model [`SRAM_DEPTH];
    axi_data_t   cmp_model;
    logic [31:0] lfsr;
    logic [1:0]  busy;
    logic        built;
    int          cyc;
    int          uart_count;
    logic [7:0]  uart_byte;
    int          checks;
    int          errors;

    soc_bus_top i_soc_bus_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .m0_araddr     (araddr[0]),
        .m0_arvalid    (arvalid[0]),
        .m0_arready    (arready[0]),
        .m0_rdata      (rdata[0]),
        .m0_rresp      (rresp[0]),
        .m0_rvalid     (rvalid[0]),
        .m0_rready     (rready[0]),
        .m0_awaddr     (awaddr[0]),
        .m0_awvalid    (awvalid[0]),
        .m0_awready    (awready[0]),
        .m0_wdata      (wdata[0]),
        .m0_wstrb      (wstrb[0]),
        .m0_wvalid     (wvalid[0]),
        .m0_wready     (wready[0]),
        .m0_bresp      (bresp[0]),
        .m0_bvalid     (bvalid[0]),
        .m0_bready     (bready[0]),
        .m1_araddr     (araddr[1]),
        .m1_arvalid    (arvalid[1]),
        .m1_arready    (arready[1]),
        .m1_rdata      (rdata[1]),
        .m1_rresp      (rresp[1]),
        .m1_rvalid     (rvalid[1]),
        .m1_rready     (rready[1]),
        .m1_awaddr     (awaddr[1]),
        .m1_awvalid    (awvalid[1]),
        .m1_awready    (awready[1]),
        .m1_wdata      (wdata[1]),
        .m1_wstrb      (wstrb[1]),
        .m1_wvalid     (wvalid[1]),
        .m1_wready     (wready[1]),
        .m1_bresp      (bresp[1]),
        .m1_bvalid     (bvalid[1]),
        .m1_bready     (bready[1]),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .timer_irq     (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (uart_tx_valid) begin
                uart_count <= uart_count + 1;
                uart_byte  <= uart_tx_data;
            end
            for (int m = 0; m < 2; m++) begin
                assert (busy[m] || !(rvalid[m] || bvalid[m])) else begin
                    errors++;
                    $display("[ERROR] master %0d got a response it never asked for", m);
                end
            end
        end
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t data,
                                              input axi_strb_t strb);
        axi_data_t res;
        res = old;
        for (int b = 0; b < `AXI_STRB_W; b++) begin
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int word_index(input axi_addr_t addr);
        return (addr >> 2) % `SRAM_DEPTH;
    endfunction

    function automatic axi_data_t model_read(input axi_addr_t addr);
        if (addr == `UART_TX_ADDR)
            return '0;
        if (addr == `CLINT_MTIMECMP_ADDR)
            return cmp_model;
        return sram_model[word_index(addr)];
    endfunction

    task automatic model_write(input axi_addr_t addr, input axi_data_t data,
                               input axi_strb_t strb);
        if (addr == `CLINT_MTIMECMP_ADDR)
            cmp_model = merge_bytes(cmp_model, data, strb);
        else if (addr != `UART_TX_ADDR && addr != `CLINT_MTIME_ADDR)
            sram_model[word_index(addr)] = merge_bytes(sram_model[word_index(addr)], data, strb);
    endtask

    task automatic check_value(input string name, input axi_data_t exp, input axi_data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_true(input string name, input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %s: %s", name, what);
        end
    endtask

    task automatic add_entry(input string name, input tb_op_t op, input logic master,
                             input axi_addr_t addr, input axi_data_t data,
                             input axi_strb_t strb, input int hold);
        entry_t e;
        e.op     = op;
        e.master = master;
        e.addr   = addr;
        e.data   = data;
        e.strb   = strb;
        e.hold   = hold;
        e.exp_a  = '0;
        e.exp_b  = '0;
        case (op)
            op_write, op_uart: model_write(addr, data, strb);
            op_read: e.exp_a = model_read(addr);
            op_dual: begin
                model_write(addr, data, strb);
                model_write(addr ^ 32'h4, ~data, strb);
                e.exp_a = model_read(addr);
                e.exp_b = model_read(addr ^ 32'h4);
            end
            op_stall: begin
                e.exp_a = model_read(addr);
                e.exp_b = model_read(`UART_TX_ADDR);
            end
            op_irq: cmp_model = '1;
            default: ;
        endcase
        table_q.push_back(e);
        names_q.push_back(name);
    endtask

    task automatic build_table();
        axi_addr_t addrs [4];
        axi_addr_t a;
        axi_data_t d;
        axi_strb_t s;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = rand_bits(8) << 2;
            d = rand_bits(32);
            add_entry($sformatf("sram_full_wr%0d", i), op_write, i[0], addrs[i], d, 4'hf, 0);
        end
        for (int i = 0; i < 4; i++) begin
            d = rand_bits(32);
            s = rand_bits(4);
            add_entry($sformatf("sram_part_wr%0d", i), op_write, !i[0], addrs[i], d, s, 0);
        end
        for (int i = 0; i < 4; i++)
            add_entry($sformatf("sram_rd%0d", i), op_read, i[0], addrs[i], '0, '0, 0);
        // SRAM word that a misrouted UART access would hit
        d = rand_bits(32);
        add_entry("uart_alias_wr", op_write, 1'b1, 32'h3f8, d, 4'hf, 0);
        d = rand_bits(32);
        add_entry("uart_tx", op_uart, 1'b1, `UART_TX_ADDR, d, 4'hf, 0);
        add_entry("uart_rd", op_read, 1'b0, `UART_TX_ADDR, '0, '0, 0);
        add_entry("uart_alias_rd", op_read, 1'b0, 32'h3f8, '0, '0, 0);
        add_entry("mtime_pair", op_mtime, 1'b1, `CLINT_MTIME_ADDR, '0, '0, 0);
        add_entry("mtimecmp_reset", op_read, 1'b1, `CLINT_MTIMECMP_ADDR, '0, '0, 0);
        add_entry("timer_irq", op_irq, 1'b0, `CLINT_MTIMECMP_ADDR, '0, '0, 0);
        add_entry("mtimecmp_rd", op_read, 1'b0, `CLINT_MTIMECMP_ADDR, '0, '0, 0);
        for (int i = 0; i < 2; i++) begin
            a = rand_bits(8) << 2;
            d = rand_bits(32);
            add_entry($sformatf("dual%0d", i), op_dual, 1'b0, a, d, 4'hf, 0);
        end
        add_entry("stall_m0", op_stall, 1'b0, addrs[0], '0, '0, 1 + rand_bits(3));
        add_entry("stall_m1", op_stall, 1'b1, addrs[1], '0, '0, 1 + rand_bits(3));
    endtask

    // One transaction on master port m with the response held off for hold cycles
    task automatic bus_access(input int m, input logic wr, input axi_addr_t addr,
                              input axi_data_t data, input axi_strb_t strb, input int hold,
                              input string name, output axi_data_t rd, output int done_cyc);
        axi_data_t held;
        @(negedge clk);
        if (wr) begin
            awaddr[m]  = addr;
            wdata[m]   = data;
            wstrb[m]   = strb;
            awvalid[m] = 1'b1;
            wvalid[m]  = 1'b1;
        end else begin
            araddr[m]  = addr;
            arvalid[m] = 1'b1;
        end
        #QTR;
        while (!(wr ? (awready[m] && wready[m]) : arready[m])) begin
            @(negedge clk);
            #QTR;
        end
        // Address taken at the coming rising edge
        busy[m] = 1'b1;
        @(negedge clk);
        arvalid[m] = 1'b0;
        awvalid[m] = 1'b0;
        wvalid[m]  = 1'b0;
        #QTR;
        while (!(wr ? bvalid[m] : rvalid[m])) begin
            @(negedge clk);
            #QTR;
        end
        held = rdata[m];
        repeat (hold) begin
            @(negedge clk);
            #QTR;
            check_true(name, rvalid[m], "rvalid dropped while rready was low");
            check_value({name, " held rdata"}, held, rdata[m]);
        end
        @(negedge clk);
        rready[m] = !wr;
        bready[m] = wr;
        #QTR;
        check_true(name, wr ? bvalid[m] : rvalid[m], "response vanished before it was taken");
        check_value({name, " resp"}, '0, wr ? bresp[m] : rresp[m]);
        rd       = rdata[m];
        done_cyc = cyc;
        @(negedge clk);
        rready[m] = 1'b0;
        bready[m] = 1'b0;
        busy[m]   = 1'b0;
    endtask

    task automatic run_entry(input int i);
        entry_t    e;
        string     name;
        axi_data_t rd0;
        axi_data_t rd1;
        int        dc0;
        int        dc1;
        int        start;
        e    = table_q[i];
        name = names_q[i];
        case (e.op)
            op_write: bus_access(e.master, 1'b1, e.addr, e.data, e.strb, 0, name, rd0, dc0);
            op_read: begin
                bus_access(e.master, 1'b0, e.addr, '0, '0, 0, name, rd0, dc0);
                check_value(name, e.exp_a, rd0);
            end
            op_uart: begin
                start = uart_count;
                bus_access(e.master, 1'b1, e.addr, e.data, e.strb, 0, name, rd0, dc0);
                @(negedge clk);
                check_value({name, " pulses"}, 1, uart_count - start);
                check_value({name, " tx_data"}, e.data[7:0], uart_byte);
            end
            op_mtime: begin
                check_value({name, " irq"}, 0, timer_irq);
                bus_access(e.master, 1'b0, e.addr, '0, '0, 0, name, rd0, dc0);
                bus_access(e.master, 1'b0, e.addr, '0, '0, 0, name, rd1, dc1);
                check_true(name, rd1 > rd0, "second mtime read is not above the first");
            end
            op_irq: begin
                bus_access(e.master, 1'b0, `CLINT_MTIME_ADDR, '0, '0, 0, name, rd0, dc0);
                bus_access(e.master, 1'b1, e.addr, rd0 + 50, 4'hf, 0, name, rd1, dc1);
                while (!timer_irq) begin
                    @(negedge clk);
                end
                // dc0 - 1 is the cycle in which mtime was sampled
                start = cyc - (dc0 - 1);
                check_true(name, start >= 50 && start <= 60,
                           $sformatf("timer_irq rose %0d cycles after the mtime read", start));
                bus_access(e.master, 1'b1, e.addr, '1, 4'hf, 0, name, rd1, dc1);
                @(negedge clk);
                check_value({name, " cleared"}, 0, timer_irq);
            end
            op_dual: begin
                fork
                    bus_access(0, 1'b1, e.addr, e.data, e.strb, 0, {name, " m0 wr"}, rd0, dc0);
                    bus_access(1, 1'b1, e.addr ^ 32'h4, ~e.data, e.strb, 0, {name, " m1 wr"},
                               rd1, dc1);
                join
                fork
                    bus_access(0, 1'b0, e.addr, '0, '0, 0, {name, " m0 rd"}, rd0, dc0);
                    bus_access(1, 1'b0, e.addr ^ 32'h4, '0, '0, 0, {name, " m1 rd"}, rd1, dc1);
                join
                check_value({name, " m0"}, e.exp_a, rd0);
                check_value({name, " m1"}, e.exp_b, rd1);
            end
            op_stall: begin
                fork
                    bus_access(e.master, 1'b0, e.addr, '0, '0, e.hold, name, rd0, dc0);
                    begin
                        @(negedge clk);
                        bus_access(!e.master, 1'b0, `UART_TX_ADDR, '0, '0, 0, {name, " other"},
                                   rd1, dc1);
                    end
                join
                check_value(name, e.exp_a, rd0);
                check_value({name, " other"}, e.exp_b, rd1);
                check_true(name, dc1 > dc0, "other master finished before the stalled read");
            end
            default: check_true(name, 1'b0, "table entry has an unknown operation");
        endcase
    endtask

    initial begin
        rst_n      = 1'b0;
        araddr     = '0;
        arvalid    = '0;
        rready     = '0;
        awaddr     = '0;
        awvalid    = '0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = '0;
        bready     = '0;
        busy       = '0;
        built      = 1'b0;
        cyc        = 0;
        uart_count = 0;
        uart_byte  = '0;
        checks     = 0;
        errors     = 0;
        cmp_model  = '1;
        lfsr       = 32'h41bb;
        build_table();
        built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < table_q.size(); i++)
            run_entry(i);
        repeat (4) @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (built);
        repeat (table_q.size() * 200 + 2000) @(posedge clk);
        $display("Timeout: the tests did not finish in the allowed number of cycles");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/soc_bus_pkg.sv
hw/axi_lite_if.sv
hw/axi_arbiter.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/axi_uart.sv
hw/axi_clint.sv
hw/soc_bus_top.sv
sim/tb_soc_bus.sv
